/* vlog.f */
source/az_pkg.sv
source/adc_sample_if.sv
source/az_sequencer.sv
source/adc_capture.sv
source/az_combiner.sv
source/az_frontend.sv
verification/az_checker.sv
verification/tb_az_frontend.sv

/* Bender.yml */
package:
  name: az_frontend

sources:
  # rtl
  - files:
      - source/az_pkg.sv
      - source/adc_sample_if.sv
      - source/az_sequencer.sv
      - source/adc_capture.sv
      - source/az_combiner.sv
      - source/az_frontend.sv

  # verification
  - target: test
    files:
      - verification/az_checker.sv
      - verification/tb_az_frontend.sv

/* verification/tb_az_frontend.sv */
`timescale 1ns/100ps

module tb_az_frontend;

  localparam int PRECHARGE   = 6;
  localparam int NUM_ENTRIES = 10;
  // cycles a single wait may take before the run is abandoned
  localparam int WAIT_LIMIT  = 2000;
  localparam logic [3:0] LO_SEL = 4'd3;

  logic                               clk;
  logic                               reset;
  logic [3:0]                         azmux_lo;
  logic                               adc_done;
  logic [az_pkg::ADC_W-1:0]           adc_word;
  logic                               result_ready;
  logic                               adc_start;
  logic                               sw_pc_ctl;
  logic [3:0]                         azmux;
  logic                               result_valid;
  logic                               result_over_range;
  logic signed [az_pkg::RESULT_W-1:0] result;

  // stimulus table, one hi/lo pair per entry with the expected result
  logic [az_pkg::ADC_W-1:0]           hi_tab [NUM_ENTRIES];
  logic [az_pkg::ADC_W-1:0]           lo_tab [NUM_ENTRIES];
  logic signed [az_pkg::RESULT_W-1:0] exp_tab [NUM_ENTRIES];
  logic                               ovr_tab [NUM_ENTRIES];

  int                                 result_count;
  int                                 mismatch_count;
  int                                 check_fail_count;
  int                                 timeout_count;
  logic signed [az_pkg::RESULT_W-1:0] exp_result;
  logic                               exp_over_range;
  // adc model saw no start within its wait limit
  logic                               adc_stuck;

  // results arrive in table order, so the next one is indexed by the count
  assign exp_result     = (result_count < NUM_ENTRIES) ? exp_tab[result_count] : '0;
  assign exp_over_range = (result_count < NUM_ENTRIES) ? ovr_tab[result_count] : 1'b0;

  az_frontend #(
    .PRECHARGE_CYCLES (PRECHARGE)
  ) u_az_frontend (
    .clk               (clk),
    .reset             (reset),
    .azmux_lo          (azmux_lo),
    .sw_pc_ctl         (sw_pc_ctl),
    .azmux             (azmux),
    .adc_start         (adc_start),
    .adc_done          (adc_done),
    .adc_word          (adc_word),
    .result_valid      (result_valid),
    .result_ready      (result_ready),
    .result            (result),
    .result_over_range (result_over_range)
  );

  az_checker #(
    .PRECHARGE_CYCLES (PRECHARGE)
  ) u_az_checker (
    .clk               (clk),
    .reset             (reset),
    .azmux_lo          (azmux_lo),
    .adc_start         (adc_start),
    .sw_pc_ctl         (sw_pc_ctl),
    .azmux             (azmux),
    .result_valid      (result_valid),
    .result_ready      (result_ready),
    .result            (result),
    .result_over_range (result_over_range),
    .exp_result        (exp_result),
    .exp_over_range    (exp_over_range),
    .result_count      (result_count),
    .mismatch_count    (mismatch_count),
    .fail_count        (check_fail_count)
  );

  // 40 ns period
  initial
    clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic set_entry(input int idx, input logic [az_pkg::ADC_W-1:0] hi,
                           input logic [az_pkg::ADC_W-1:0] lo,
                           input logic signed [az_pkg::RESULT_W-1:0] exp,
                           input logic ovr);
    hi_tab[idx]  = hi;
    lo_tab[idx]  = lo;
    exp_tab[idx] = exp;
    ovr_tab[idx] = ovr;
  endtask

  // closing line with the counts, then the verdict
  task automatic finish_run();
    int other;
    other = check_fail_count + timeout_count;
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other);
    if (mismatch_count == 0 && other == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  endtask

  task automatic give_up(input string what);
    $display("timeout at %0t: %s", $time, what);
    timeout_count++;
    finish_run();
  endtask

  // next conversion request from the sequencer
  task automatic wait_start(output logic seen);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!adc_start && cycles < WAIT_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    seen = adc_start;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin : main
    int cycles;
    void'($urandom(44));
    reset         = 1'b1;
    azmux_lo      = LO_SEL;
    adc_done      = 1'b0;
    adc_word      = '0;
    result_ready  = 1'b0;
    timeout_count = 0;
    adc_stuck     = 1'b0;
    // hi, lo, hi minus lo, over-range flag
    set_entry(0, 24'h100000, 24'h000010,  25'sd1048560, 1'b0);
    set_entry(1, 24'h000100, 24'h000200,  -25'sd256,    1'b0);
    set_entry(2, 24'h3FFFFF, 24'h000000,  25'sd4194303, 1'b0);
    set_entry(3, 24'h000000, 24'h3FFFFF, -25'sd4194303, 1'b0);
    set_entry(4, 24'h800005, 24'h000005,  25'sd8388608, 1'b1);
    set_entry(5, 24'h012345, 24'h412345, -25'sd4194304, 1'b1);
    set_entry(6, 24'hFFFFFF, 24'h000000, 25'sd16777215, 1'b1);
    set_entry(7, 24'h000000, 24'hFFFFFF, -25'sd16777215, 1'b1);
    set_entry(8, 24'h2AAAAA, 24'h155555,  25'sd1398101, 1'b0);
    set_entry(9, 24'h00ABCD, 24'h00ABCE,  -25'sd1,      1'b0);
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    // sampled on the falling edge, away from the checker's updates
    cycles = 0;
    while (result_count < NUM_ENTRIES && !adc_stuck && cycles < WAIT_LIMIT * NUM_ENTRIES)
    begin
      @(negedge clk);
      cycles++;
    end
    if (adc_stuck)
      give_up("sequencer never issued the next adc_start");
    else if (result_count < NUM_ENTRIES)
      give_up("results stopped arriving before the table was done");
    else
      finish_run();
  end

  ////////////////////////////////////////
  // adc model
  ////////////////////////////////////////

  // answers each start after 3 to 10 cycles, hi word while the switch is at signal
  initial
  begin : adc_model
    int   idx;
    int   delay;
    logic hi_phase;
    logic seen;
    idx  = 0;
    seen = 1'b1;
    while (idx < NUM_ENTRIES && seen)
    begin
      wait_start(seen);
      if (seen)
      begin
        hi_phase = (sw_pc_ctl == az_pkg::SW_PC_SIGNAL);
        delay    = 3 + ($urandom % 8);
        repeat (delay - 1) @(posedge clk);
        #2;
        adc_done = 1'b1;
        adc_word = hi_phase ? hi_tab[idx] : lo_tab[idx];
        @(posedge clk);
        #2;
        adc_done = 1'b0;
        // the lo word closes the entry
        if (!hi_phase)
          idx++;
      end
    end
    if (!seen)
      adc_stuck = 1'b1;
  end

  // consumer with short random gaps and the odd long stall
  initial
  begin : consumer
    int stall;
    stall = 0;
    forever
    begin
      @(posedge clk);
      #2;
      if (stall > 0)
      begin
        result_ready = 1'b0;
        stall--;
      end
      else if ($urandom % 16 == 0)
      begin
        result_ready = 1'b0;
        stall        = 25;
      end
      else
        result_ready = ($urandom % 3 != 0);
    end
  end

endmodule

/* verification/az_checker.sv */
`timescale 1ns/100ps

module az_checker #(
  parameter int PRECHARGE_CYCLES = 10000
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [3:0]                         azmux_lo,
  input  logic                               adc_start,
  input  logic                               sw_pc_ctl,
  input  logic [3:0]                         azmux,
  input  logic                               result_valid,
  input  logic                               result_ready,
  input  logic signed [az_pkg::RESULT_W-1:0] result,
  input  logic                               result_over_range,
  input  logic signed [az_pkg::RESULT_W-1:0] exp_result,
  input  logic                               exp_over_range,
  output int                                 result_count,
  output int                                 mismatch_count,
  output int                                 fail_count
);

  int                                 cycle_no;
  int                                 boot_cycle;
  int                                 hi_sel_cycle;
  int                                 start_count;
  // conversions alternate hi, lo, starting with hi
  logic                               expect_hi;
  logic                               sw_q;
  logic [3:0]                         azmux_q;
  logic                               stall_q;
  logic signed [az_pkg::RESULT_W-1:0] result_q;
  logic                               ovr_q;

  initial
  begin
    cycle_no       = 0;
    mismatch_count = 0;
    fail_count     = 0;
    result_count   = 0;
  end

  task automatic report_mismatch(input string name, input logic signed [63:0] exp,
                                 input logic signed [63:0] got);
    $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
    mismatch_count++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    fail_count++;
  endtask

  always @(posedge clk)
  begin
    cycle_no++;
    if (reset)
    begin
      ////////////////////////////////////////
      // reset state, every flop has seen reset by the second clock
      if (cycle_no > 1)
      begin
        if (adc_start !== 1'b0)
          report_mismatch("adc_start", 0, adc_start);
        if (result_valid !== 1'b0)
          report_mismatch("result_valid", 0, result_valid);
        if (sw_pc_ctl !== az_pkg::SW_PC_BOOT)
          report_mismatch("sw_pc_ctl", az_pkg::SW_PC_BOOT, sw_pc_ctl);
        if (azmux !== azmux_lo)
          report_mismatch("azmux", azmux_lo, azmux);
      end
      expect_hi    = 1'b1;
      start_count  = 0;
      boot_cycle   = cycle_no;
      hi_sel_cycle = cycle_no;
    end
    else
    begin
      ////////////////////////////////////////
      // switch protection and settle times
      if (sw_pc_ctl == az_pkg::SW_PC_SIGNAL && azmux != az_pkg::AZMUX_HI)
        report_failure("pre-charge switch at signal while az mux is off the hi select");
      if (sw_q == az_pkg::SW_PC_SIGNAL && sw_pc_ctl == az_pkg::SW_PC_BOOT)
        boot_cycle = cycle_no;
      if (azmux_q == az_pkg::AZMUX_HI && azmux == azmux_lo &&
          cycle_no - boot_cycle < PRECHARGE_CYCLES)
        report_failure("az mux went to lo before the re-protect settle time");
      if (azmux_q != az_pkg::AZMUX_HI && azmux == az_pkg::AZMUX_HI)
        hi_sel_cycle = cycle_no;
      if (sw_q == az_pkg::SW_PC_BOOT && sw_pc_ctl == az_pkg::SW_PC_SIGNAL &&
          cycle_no - hi_sel_cycle < PRECHARGE_CYCLES)
        report_failure("switch moved to signal before the precharge settle time");

      // each start matches the phase it belongs to
      if (adc_start)
      begin
        if (expect_hi && sw_pc_ctl !== az_pkg::SW_PC_SIGNAL)
          report_mismatch("sw_pc_ctl", az_pkg::SW_PC_SIGNAL, sw_pc_ctl);
        if (!expect_hi && azmux !== azmux_lo)
          report_mismatch("azmux", azmux_lo, azmux);
        start_count++;
        // at most a pending pair plus one word buffered or converting
        if (start_count - 2 * result_count > 3)
          report_failure("adc_start issued while the result path was full");
        expect_hi = !expect_hi;
      end

      ////////////////////////////////////////
      // result port
      if (stall_q && (result_valid !== 1'b1 || result !== result_q ||
                      result_over_range !== ovr_q))
        report_failure("result changed while the consumer was stalling");
      if (result_valid && result_ready)
      begin
        if (result !== exp_result)
          report_mismatch("result", exp_result, result);
        if (result_over_range !== exp_over_range)
          report_mismatch("result_over_range", exp_over_range, result_over_range);
        result_count++;
      end
    end
    sw_q     = sw_pc_ctl;
    azmux_q  = azmux;
    stall_q  = result_valid && !result_ready;
    result_q = result;
    ovr_q    = result_over_range;
  end

endmodule

/* source/az_frontend.sv */
`timescale 1ns/100ps

module az_frontend #(
  // settle time for each switch change, in clocks
  parameter int PRECHARGE_CYCLES = 10000
) (
  input  logic                                clk,
  input  logic                                reset,

  // analog switch control
  input  logic [3:0]                          azmux_lo,
  output logic                                sw_pc_ctl,
  output logic [3:0]                          azmux,

  // adc port
  output logic                                adc_start,
  input  logic                                adc_done,
  input  logic [az_pkg::ADC_W-1:0]            adc_word,

  // auto-zeroed result
  output logic                                result_valid,
  input  logic                                result_ready,
  output logic signed [az_pkg::RESULT_W-1:0]  result,
  output logic                                result_over_range
);

  logic phase_hi;
  logic sample_free;

  // capture to combiner
  adc_sample_if smp_if ();

  ////////////////////////////////////////
  // switch and adc sequencing
  az_sequencer #(
    .PRECHARGE_CYCLES (PRECHARGE_CYCLES)
  ) u_az_sequencer (
    .clk         (clk),
    .reset       (reset),
    .azmux_lo    (azmux_lo),
    .adc_done    (adc_done),
    .sample_free (sample_free),
    .adc_start   (adc_start),
    .sw_pc_ctl   (sw_pc_ctl),
    .phase_hi    (phase_hi),
    .azmux       (azmux)
  );

  // word capture, runs on the same adc_done as the sequencer
  adc_capture u_adc_capture (
    .clk         (clk),
    .reset       (reset),
    .adc_done    (adc_done),
    .phase_hi    (phase_hi),
    .adc_word    (adc_word),
    .sample_free (sample_free),
    .smp         (smp_if.source)
  );

  // hi minus lo
  az_combiner u_az_combiner (
    .clk               (clk),
    .reset             (reset),
    .smp               (smp_if.sink),
    .result_ready      (result_ready),
    .result_valid      (result_valid),
    .result_over_range (result_over_range),
    .result            (result)
  );

endmodule

/* source/az_combiner.sv */
`timescale 1ns/100ps

module az_combiner (
  input  logic                                clk,
  input  logic                                reset,
  adc_sample_if.sink                          smp,
  input  logic                                result_ready,
  output logic                                result_valid,
  output logic                                result_over_range,
  output logic signed [az_pkg::RESULT_W-1:0]  result
);

  // stored hi sample
  logic                    hi_held;
  logic [az_pkg::ADC_W-1:0] hi_raw;
  logic                    hi_range_bad;

  // range status of the incoming word, either direction counts
  logic smp_range_bad;
  logic take;

  assign smp_range_bad = smp.word.status.over_range | smp.word.status.under_range;

  // one pending result at a time, stall capture until it is taken
  assign smp.ready = !result_valid;
  assign take      = smp.valid && smp.ready;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hi_held      <= 1'b0;
      result_valid <= 1'b0;
    end
    else
    begin
      if (result_valid && result_ready)
        result_valid <= 1'b0;

      if (take)
      begin
        if (smp.is_hi)
          hi_held <= 1'b1;
        else if (hi_held)
        begin
          // lo completes the pair
          hi_held      <= 1'b0;
          result_valid <= 1'b1;
        end
        // lo with no hi ahead of it is dropped, only seen right after reset
      end
    end
  end

  ////////////////////////////////////////
  // data
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (take && smp.is_hi)
    begin
      hi_raw       <= smp.word.raw;
      hi_range_bad <= smp_range_bad;
    end

    if (take && !smp.is_hi && hi_held)
    begin
      // counts are unsigned, widen by one bit then subtract
      result            <= $signed({1'b0, hi_raw}) - $signed({1'b0, smp.word.raw});
      result_over_range <= hi_range_bad | smp_range_bad;
    end
  end

  // offered result holds until the consumer takes it
  a_result_hold: assert property (
    @(posedge clk) disable iff (reset)
    (result_valid && !result_ready) |=>
      (result_valid && $stable(result) && $stable(result_over_range))
  );

endmodule

/* source/adc_capture.sv */
`timescale 1ns/100ps

module adc_capture (
  input  logic              clk,
  input  logic              reset,
  input  logic              adc_done,
  // phase of the conversion that is finishing
  input  logic              phase_hi,
  input  az_pkg::adc_word_u adc_word,
  output logic              sample_free,
  adc_sample_if.source      smp
);

  // one-entry buffer
  logic              full;
  az_pkg::adc_word_u word_q;
  logic              is_hi_q;

  ////////////////////////////////////////
  // buffer occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      full <= 1'b0;
    else if (adc_done)
      // sequencer only starts into an empty buffer
      full <= 1'b1;
    else if (smp.valid && smp.ready)
      full <= 1'b0;
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  // word and tag are loaded together, held until the combiner takes them
  always_ff @(posedge clk)
  begin
    if (adc_done)
    begin
      word_q.raw <= adc_word.raw;
      is_hi_q    <= phase_hi;
    end
  end

  // offer the buffered sample
  assign smp.valid = full;
  assign smp.word  = word_q;
  assign smp.is_hi = is_hi_q;

  // back-pressure to the sequencer
  assign sample_free = !full;

  // a conversion must never land on top of an unread word
  a_no_overrun: assert property (
    @(posedge clk) disable iff (reset)
    adc_done |-> !full
  );

endmodule

/* source/az_sequencer.sv */
`timescale 1ns/100ps

module az_sequencer #(
  // settle time for each switch change, in clocks
  parameter int PRECHARGE_CYCLES = 10000
) (
  input  logic       clk,
  input  logic       reset,
  // lo reference select code, static
  input  logic [3:0] azmux_lo,
  input  logic       adc_done,
  // capture buffer is empty
  input  logic       sample_free,
  output logic       adc_start,
  output logic       sw_pc_ctl,
  output logic       phase_hi,
  output logic [3:0] azmux
);

  // counter wide enough to hold PRECHARGE_CYCLES-1
  localparam int CNT_W = (PRECHARGE_CYCLES > 1) ? $clog2(PRECHARGE_CYCLES) : 1;
  localparam logic [CNT_W-1:0] SETTLE_LOAD = CNT_W'(PRECHARGE_CYCLES - 1);

  // state codes
  localparam logic [2:0] ST_BOOT     = 3'd0;
  localparam logic [2:0] ST_HI_SEL   = 3'd1;
  localparam logic [2:0] ST_HI_START = 3'd2;
  localparam logic [2:0] ST_HI_WAIT  = 3'd3;
  localparam logic [2:0] ST_PROTECT  = 3'd4;
  localparam logic [2:0] ST_LO_START = 3'd5;
  localparam logic [2:0] ST_LO_WAIT  = 3'd6;

  logic [2:0]       state;
  logic [CNT_W-1:0] settle_cnt;
  // az mux points at the pre-charge output when set, otherwise at lo
  logic             sel_hi;

  // mux code follows the select bit, so reset gives azmux_lo directly
  assign azmux = sel_hi ? az_pkg::AZMUX_HI : azmux_lo;

  // tag for the capture block, valid while the hi conversion runs
  assign phase_hi = (state == ST_HI_WAIT);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state      <= ST_BOOT;
      settle_cnt <= SETTLE_LOAD;
      sw_pc_ctl  <= az_pkg::SW_PC_BOOT;
      sel_hi     <= 1'b0;
      adc_start  <= 1'b0;
    end
    else
    begin
      // start is a single cycle pulse
      adc_start <= 1'b0;

      case (state)

        ////////////////////////////////////////
        // signal protected, mux on lo
        ST_BOOT:
        begin
          if (settle_cnt == '0)
          begin
            // swing the az mux onto the pre-charge output
            sel_hi     <= 1'b1;
            settle_cnt <= SETTLE_LOAD;
            state      <= ST_HI_SEL;
          end
          else
            settle_cnt <= settle_cnt - 1'b1;
        end

        ////////////////////////////////////////
        // precharge phase
        // mux on hi, switch still on boot, let the charge settle
        ST_HI_SEL:
        begin
          if (settle_cnt == '0)
            state <= ST_HI_START;
          else
            settle_cnt <= settle_cnt - 1'b1;
        end

        // hold off until capture can take another word
        ST_HI_START:
        begin
          if (sample_free)
          begin
            sw_pc_ctl <= az_pkg::SW_PC_SIGNAL;
            adc_start <= 1'b1;
            state     <= ST_HI_WAIT;
          end
        end

        // hi conversion running, adc time varies
        ST_HI_WAIT:
        begin
          if (adc_done)
          begin
            // back to boot before touching the mux again
            sw_pc_ctl  <= az_pkg::SW_PC_BOOT;
            settle_cnt <= SETTLE_LOAD;
            state      <= ST_PROTECT;
          end
        end

        ////////////////////////////////////////
        // re-protect the signal before the mux leaves hi
        ST_PROTECT:
        begin
          if (settle_cnt == '0)
          begin
            sel_hi <= 1'b0;
            state  <= ST_LO_START;
          end
          else
            settle_cnt <= settle_cnt - 1'b1;
        end

        // mux on lo, start once the buffer is empty
        ST_LO_START:
        begin
          if (sample_free)
          begin
            adc_start <= 1'b1;
            state     <= ST_LO_WAIT;
          end
        end

        // lo conversion running, then around again from the hi select
        ST_LO_WAIT:
        begin
          if (adc_done)
          begin
            sel_hi     <= 1'b1;
            settle_cnt <= SETTLE_LOAD;
            state      <= ST_HI_SEL;
          end
        end

        default:
          state <= ST_BOOT;

      endcase
    end
  end

  // start never stretches beyond one clock
  a_start_pulse: assert property (
    @(posedge clk) disable iff (reset)
    adc_start |=> !adc_start
  );

  // signal path only opens while the mux looks at the pre-charge output
  a_switch_guard: assert property (
    @(posedge clk) disable iff (reset)
    (sw_pc_ctl == az_pkg::SW_PC_SIGNAL) |-> (azmux == az_pkg::AZMUX_HI)
  );

endmodule

/* source/adc_sample_if.sv */
`timescale 1ns/100ps

// tagged conversion sample, capture block to combiner
// transfer happens on a clock with valid and ready both high
interface adc_sample_if;

  // capture side
  logic             valid;
  az_pkg::adc_word_u word;
  // high when the word came from the hi (signal) phase
  logic             is_hi;

  // combiner side
  logic             ready;

  // producer of samples
  modport source (
    output valid,
    output word,
    output is_hi,
    input  ready
  );

  // consumer of samples
  modport sink (
    input  valid,
    input  word,
    input  is_hi,
    output ready
  );

endinterface

/* source/az_pkg.sv */
package az_pkg;

  ////////////////////////////////////////
  // adc word geometry
  ////////////////////////////////////////

  // full conversion word as delivered by the adc
  localparam int ADC_W = 24;

  // magnitude part of the word, below the two range bits
  localparam int MAG_W = 22;

  // hi minus lo needs one extra bit for the sign
  localparam int RESULT_W = ADC_W + 1;

  // one conversion word, seen either as a plain count
  // or split into range status and magnitude
  typedef union packed {
    logic [ADC_W-1:0] raw;
    struct packed {
      logic             over_range;
      logic             under_range;
      logic [MAG_W-1:0] magnitude;
    } status;
  } adc_word_u;

  ////////////////////////////////////////
  // analog switch codes
  ////////////////////////////////////////

  // az mux select that routes the pre-charge switch output to the integrator
  localparam logic [3:0] AZMUX_HI = 4'd8;

  // pre-charge switch positions
  // boot keeps the signal input isolated from az mux charge injection
  localparam logic SW_PC_BOOT   = 1'b0;
  localparam logic SW_PC_SIGNAL = 1'b1;

endpackage
